// ==== Bender.yml ====
package:
  name: hispi_rx

sources:
  - hispi_pkg.sv
  - lane_gearbox.sv
  - word_aligner.sv
  - sync_decoder.sv
  - hispi_rx.sv
  - target: test
    files:
      - hispi_sensor_model.sv
      - hispi_rx_tb.sv

// ==== hispi_pkg.sv ====
// hispi receive shared definitions
// lane and word widths, sync and code words, lane bundles, decoder states
package hispi_pkg;

	// ----------------------------------------
	// geometry
	// ----------------------------------------
	// four lanes, six bits per lane per clk
	localparam int lane_num = 4;
	localparam int slice_w  = 6;
	// one pixel per lane per two clks
	localparam int word_w   = 12;
	// lane 0 history spans the three sync words
	localparam int hist_w   = 3 * word_w;

	// ----------------------------------------
	// vector types
	// ----------------------------------------
	typedef logic [slice_w-1:0] slice_t;
	typedef logic [word_w-1:0]  word_t;
	// line period in clk cycles minus one
	typedef logic [15:0]        line_len_t;
	// gearbox bit offset
	typedef logic [2:0]         slip_t;

	// largest legal gearbox offset
	localparam slip_t slip_max = slip_t'(slice_w - 1);

	// ----------------------------------------
	// lane bundles
	// ----------------------------------------
	// lane 0 sits in the lowest bits
	typedef struct packed {
		slice_t [lane_num-1:0] lane;
	} raw_bundle_t;

	typedef struct packed {
		word_t [lane_num-1:0] lane;
	} word_bundle_t;

	// ----------------------------------------
	// sync and code words
	// ----------------------------------------
	// in order of arrival
	localparam word_t sync_word_0 = 12'hFFF;
	localparam word_t sync_word_1 = 12'h000;
	localparam word_t sync_word_2 = 12'h000;

	// lsb first so the first word lands in the low bits
	localparam logic [hist_w-1:0] sync_seq = {sync_word_2, sync_word_1, sync_word_0};

	// streaming-sp code words after the sync
	localparam word_t code_sof = 12'h00C;
	localparam word_t code_sol = 12'h004;
	localparam word_t code_eof = 12'h00E;
	localparam word_t code_eol = 12'h006;

	// ----------------------------------------
	// decoder fsm
	// ----------------------------------------
	typedef enum logic [2:0] {
		idle,
		sync1,
		sync2,
		code,
		active
	} dec_state_t;

endpackage

// ==== hispi_rx.sv ====
// hispi receive top
// gearbox, word aligner and sync decoder in a chain
`timescale 1ns/100ps

module hispi_rx (
	input  logic                    clk,
	input  logic                    rst_n,
	input  hispi_pkg::raw_bundle_t  raw_data,
	input  hispi_pkg::line_len_t    line_length,
	input  logic                    align_en,
	output logic                    locked,
	output logic                    frame_start,
	output logic                    line_start,
	output logic                    line_end,
	output logic                    frame_end,
	output logic                    pixel_valid,
	output hispi_pkg::word_bundle_t pixels
);

	// gearbox to aligner
	hispi_pkg::raw_bundle_t  raw_shifted;
	// slip request back to the gearbox
	logic                    bitslip;
	// aligner to decoder
	logic                    word_stb;
	hispi_pkg::word_bundle_t words;

	lane_gearbox i_lane_gearbox (
		.clk         (clk),
		.rst_n       (rst_n),
		.raw_data    (raw_data),
		.bitslip     (bitslip),
		.raw_shifted (raw_shifted)
	);

	word_aligner i_word_aligner (
		.clk         (clk),
		.rst_n       (rst_n),
		.raw_shifted (raw_shifted),
		.line_length (line_length),
		.align_en    (align_en),
		.bitslip     (bitslip),
		.locked      (locked),
		.word_stb    (word_stb),
		.words       (words)
	);

	sync_decoder i_sync_decoder (
		.clk         (clk),
		.rst_n       (rst_n),
		.word_stb    (word_stb),
		.words       (words),
		.frame_start (frame_start),
		.line_start  (line_start),
		.line_end    (line_end),
		.frame_end   (frame_end),
		.pixel_valid (pixel_valid),
		.pixels      (pixels)
	);

endmodule

// ==== hispi_rx_tb.sv ====
// hispi receive testbench
// sensor model feeds the receiver, assertions and a pixel scoreboard check it
`timescale 1ns/100ps

module hispi_rx_tb;

	localparam hispi_pkg::line_len_t line_len = 16'd47;
	localparam int line_clks   = 48;
	localparam int lock_limit  = 7 * line_clks;
	localparam int line_num    = 3;
	localparam int pixel_num   = 8;
	// reset plus lock, frame and unlock for four runs
	localparam int test_num    = 13;
	localparam int cycle_limit = 8 * line_clks * test_num + 200;

	logic                    clk;
	logic                    rst_n;
	logic                    align_en;
	hispi_pkg::line_len_t    line_length;
	hispi_pkg::slip_t        misalign;
	hispi_pkg::raw_bundle_t  raw_data;
	logic                    locked;
	logic                    frame_start;
	logic                    line_start;
	logic                    line_end;
	logic                    frame_end;
	logic                    pixel_valid;
	hispi_pkg::word_bundle_t pixels;
	logic [3:0]              markers;

	// scoreboard state
	logic        sb_on      = 1'b0;
	logic        tracking   = 1'b0;
	logic        in_line    = 1'b0;
	logic        want_frame = 1'b1;
	logic        reset_win  = 1'b0;
	int          line_idx   = 0;
	int          pix_idx    = 0;
	int          frames_done = 0;
	int          err_cnt    = 0;
	int          pass_cnt   = 0;
	int          fail_cnt   = 0;
	int          cycle_cnt  = 0;
	logic [31:0] rng_state;

	assign markers = {frame_start, line_start, line_end, frame_end};

	hispi_sensor_model i_hispi_sensor_model (
		.clk         (clk),
		.rst_n       (rst_n),
		.misalign    (misalign),
		.line_length (line_length),
		.raw_data    (raw_data)
	);

	hispi_rx i_hispi_rx (
		.clk         (clk),
		.rst_n       (rst_n),
		.raw_data    (raw_data),
		.line_length (line_length),
		.align_en    (align_en),
		.locked      (locked),
		.frame_start (frame_start),
		.line_start  (line_start),
		.line_end    (line_end),
		.frame_end   (frame_end),
		.pixel_valid (pixel_valid),
		.pixels      (pixels)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#10 clk = ~clk;
		end
	end

	// ----------------------------------------
	// protocol assertions
	// ----------------------------------------
	a_reset_quiet: assert property (@(posedge clk)
		reset_win |-> !(locked || pixel_valid || (|markers)))
		else begin
			err_cnt++;
			$display("[FAIL] %0t {locked, pixel_valid, markers} expected 000000 actual %b",
				$time, {locked, pixel_valid, markers});
		end

	a_lock_time: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(align_en) |-> ##[0:lock_limit] locked)
		else begin
			err_cnt++;
			$display("%0t: locked did not rise within %0d clks of align_en", $time, lock_limit);
		end

	a_unlock_time: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(align_en) |-> ##[1:4] !locked)
		else begin
			err_cnt++;
			$display("%0t: locked still high 4 clks after align_en fell", $time);
		end

	// pixel_valid trails word_stb by one clk
	a_quiet_unlocked: assert property (@(posedge clk) disable iff (!rst_n)
		!locked ##1 !locked |-> !pixel_valid)
		else begin
			err_cnt++;
			$display("[FAIL] %0t pixel_valid expected 0 actual %b", $time, pixel_valid);
		end

	a_one_marker: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(markers))
		else begin
			err_cnt++;
			$display("[FAIL] %0t markers expected at most one bit actual %b", $time, markers);
		end

	// ----------------------------------------
	// pixel and marker scoreboard
	// ----------------------------------------
	function automatic hispi_pkg::word_t expected_pixel(input int m, input int n, input int k);
		return hispi_pkg::word_t'(12'h100 * m + 16 * n + k);
	endfunction

	task automatic compare_pixel();
		hispi_pkg::word_t exp_word;
		assert (in_line && pix_idx < pixel_num) else begin
			err_cnt++;
			$display("%0t: pixel_valid outside a line or past %0d pixels", $time, pixel_num);
		end
		for (int k = 0; k < hispi_pkg::lane_num; k++) begin
			exp_word = expected_pixel(line_idx, pix_idx, k);
			assert (pixels.lane[k] == exp_word) else begin
				err_cnt++;
				$display("[FAIL] %0t pixels.lane[%0d] expected %h actual %h",
					$time, k, exp_word, pixels.lane[k]);
			end
		end
		pix_idx++;
	endtask

	task automatic open_line();
		assert (!in_line && frame_start == want_frame) else begin
			err_cnt++;
			$display("%0t: start marker out of order, markers %b", $time, markers);
		end
		line_idx = frame_start ? 0 : line_idx + 1;
		pix_idx  = 0;
		in_line  = 1'b1;
	endtask

	task automatic close_line();
		assert (in_line && frame_end == (line_idx == line_num - 1)) else begin
			err_cnt++;
			$display("%0t: end marker out of order, markers %b", $time, markers);
		end
		assert (pix_idx == pixel_num) else begin
			err_cnt++;
			$display("[FAIL] %0t pixel count expected %0d actual %0d", $time, pixel_num, pix_idx);
		end
		in_line    = 1'b0;
		want_frame = frame_end;
		if (frame_end) begin
			frames_done++;
		end
	endtask

	// outputs settle between edges
	always @(negedge clk) begin
		if (!sb_on) begin
			tracking = 1'b0;
		end else if (!tracking) begin
			// first full frame after lock
			if (frame_start) begin
				tracking = 1'b1;
				in_line  = 1'b1;
				line_idx = 0;
				pix_idx  = 0;
			end
		end else begin
			if (pixel_valid) begin
				compare_pixel();
			end
			if (frame_start || line_start) begin
				open_line();
			end
			if (line_end || frame_end) begin
				close_line();
			end
		end
	end

	// ----------------------------------------
	// helpers
	// ----------------------------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic lock_wait(input logic level, input int limit, output logic seen);
		int n;
		n = 0;
		while (locked !== level && n < limit) begin
			@(negedge clk);
			n++;
		end
		seen = (locked === level);
	endtask

	task automatic frame_wait(input int limit, output logic seen);
		int start;
		int n;
		start = frames_done;
		n     = 0;
		while (frames_done == start && n < limit) begin
			@(negedge clk);
			n++;
		end
		seen = (frames_done != start);
	endtask

	task automatic report_test(input string name, input int errs_before);
		if (err_cnt == errs_before) begin
			pass_cnt++;
			$display("test %s: pass", name);
		end else begin
			fail_cnt++;
			$display("test %s: fail, %0d errors", name, err_cnt - errs_before);
		end
	endtask

	// ----------------------------------------
	// timeout
	// ----------------------------------------
	initial begin
		while (cycle_cnt < cycle_limit) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("timeout: run passed %0d clk cycles", cycle_limit);
		$display("SOME TESTS FAILED");
		$finish;
	end

	// ----------------------------------------
	// stimulus
	// ----------------------------------------
	initial begin
		logic             seen;
		int               errs;
		hispi_pkg::slip_t next_m;
		rst_n       = 1'b0;
		align_en    = 1'b0;
		misalign    = '0;
		line_length = line_len;
		rng_state   = 32'h575cccc7;

		// reset, checked up to one clk after release
		errs = err_cnt;
		@(posedge clk);
		reset_win <= 1'b1;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		repeat (2) @(posedge clk);
		reset_win <= 1'b0;
		// let the last window edge report first
		@(negedge clk);
		report_test("reset", errs);

		for (int r = 0; r < 4; r++) begin
			// new bit misalignment for each run
			rng_state = xorshift32(rng_state);
			next_m    = hispi_pkg::slip_t'(rng_state % 6);
			if (r > 0 && next_m == misalign) begin
				next_m = (next_m == 3'd5) ? 3'd0 : next_m + 3'd1;
			end
			errs = err_cnt;
			@(posedge clk);
			misalign <= next_m;
			repeat (4) @(posedge clk);
			align_en <= 1'b1;
			sb_on    <= 1'b1;
			lock_wait(1'b1, lock_limit + 8, seen);
			if (!seen) begin
				err_cnt++;
				$display("%0t: no lock with misalignment %0d", $time, next_m);
			end
			report_test($sformatf("lock run %0d misalign %0d", r, next_m), errs);

			// one full frame of markers and pixels
			errs = err_cnt;
			frame_wait(7 * line_clks, seen);
			if (!seen) begin
				err_cnt++;
				$display("%0t: no complete frame after lock", $time);
			end
			report_test($sformatf("frame run %0d", r), errs);

			// drop the enable and watch the outputs go quiet
			errs = err_cnt;
			@(posedge clk);
			align_en <= 1'b0;
			sb_on    <= 1'b0;
			lock_wait(1'b0, 8, seen);
			if (!seen) begin
				err_cnt++;
				$display("%0t: locked stayed high after align_en fell", $time);
			end
			repeat (line_clks) @(negedge clk);
			report_test($sformatf("unlock run %0d", r), errs);
		end

		$display("tests %0d, passed %0d, failed %0d, errors %0d",
			pass_cnt + fail_cnt, pass_cnt, fail_cnt, err_cnt);
		if (fail_cnt == 0 && err_cnt == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== hispi_sensor_model.sv ====
// hispi sensor model
// serialises 3-line frames of known pixels into 6-bit lsb-first slices,
// delayed by a chosen number of bits
`timescale 1ns/100ps

module hispi_sensor_model (
	input  logic                   clk,
	input  logic                   rst_n,
	input  hispi_pkg::slip_t       misalign,
	input  hispi_pkg::line_len_t   line_length,
	output hispi_pkg::raw_bundle_t raw_data
);

	localparam int line_num  = 3;
	localparam int pixel_num = 8;

	// clk position inside the line period
	hispi_pkg::line_len_t   clk_cnt;
	// line inside the frame
	int                     line_idx;
	// word-aligned slices, this clk and the one before
	hispi_pkg::raw_bundle_t aligned;
	hispi_pkg::raw_bundle_t prev_slice;

	// slice sent at clk position pos of line m on lane k
	// words: sync, code, 8 pixels, sync, code, then idle zeros
	function automatic hispi_pkg::slice_t slice_at(input hispi_pkg::line_len_t pos,
		input int m, input int k);
		hispi_pkg::word_t w;
		int               wi;
		wi = int'(pos >> 1);
		if (wi == 0 || wi == 12) begin
			w = hispi_pkg::sync_word_0;
		end else if (wi == 1 || wi == 13) begin
			w = hispi_pkg::sync_word_1;
		end else if (wi == 2 || wi == 14) begin
			w = hispi_pkg::sync_word_2;
		end else if (wi == 3) begin
			w = (m == 0) ? hispi_pkg::code_sof : hispi_pkg::code_sol;
		end else if (wi == 15) begin
			w = (m == line_num - 1) ? hispi_pkg::code_eof : hispi_pkg::code_eol;
		end else if (wi >= 4 && wi < 4 + pixel_num) begin
			w = hispi_pkg::word_t'(12'h100 * m + 16 * (wi - 4) + k);
		end else begin
			w = '0;
		end
		// low half goes out first
		return pos[0] ? w[11:6] : w[5:0];
	endfunction

	always_comb begin
		for (int k = 0; k < hispi_pkg::lane_num; k++) begin
			aligned.lane[k] = slice_at(clk_cnt, line_idx, k);
		end
	end

	initial raw_data = '0;

	// ----------------------------------------
	// serialiser
	// ----------------------------------------
	always @(posedge clk or negedge rst_n) begin
		logic [2*hispi_pkg::slice_w-1:0] pair;
		if (!rst_n) begin
			clk_cnt    <= '0;
			line_idx   <= 0;
			prev_slice <= '0;
			raw_data   <= '0;
		end else begin
			prev_slice <= aligned;
			for (int k = 0; k < hispi_pkg::lane_num; k++) begin
				// whole stream delayed by misalign bits
				pair = {aligned.lane[k], prev_slice.lane[k]};
				raw_data.lane[k] <= pair[hispi_pkg::slice_w - misalign +: hispi_pkg::slice_w];
			end
			if (clk_cnt == line_length) begin
				clk_cnt  <= '0;
				line_idx <= (line_idx == line_num - 1) ? 0 : line_idx + 1;
			end else begin
				clk_cnt <= clk_cnt + 1'b1;
			end
		end
	end

endmodule

// ==== lane_gearbox.sv ====
// hispi lane gearbox
// shifts all four lanes by a common bit offset, advanced one bit per bitslip
`timescale 1ns/100ps

module lane_gearbox (
	input  logic                   clk,
	input  logic                   rst_n,
	input  hispi_pkg::raw_bundle_t raw_data,
	input  logic                   bitslip,
	output hispi_pkg::raw_bundle_t raw_shifted
);

	// previous slice of every lane
	hispi_pkg::raw_bundle_t prev_data;
	// common bit offset for all lanes
	hispi_pkg::slip_t       offset;
	// window picked from previous and current slices
	hispi_pkg::raw_bundle_t sel_data;

	// ----------------------------------------
	// offset counter
	// ----------------------------------------
	// modulo six, one step per bitslip pulse
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			offset <= '0;
		end else if (bitslip) begin
			if (offset == hispi_pkg::slip_max) begin
				offset <= '0;
			end else begin
				offset <= offset + 1'b1;
			end
		end
	end

	// ----------------------------------------
	// bit window select
	// ----------------------------------------
	// lsb first stream so the previous slice holds the earlier bits
	// offset 0 passes the current slice straight through
	// each step pulls the window one bit earlier in time
	always_comb begin
		for (int k = 0; k < hispi_pkg::lane_num; k++) begin
			sel_data.lane[k] = hispi_pkg::slice_t'(
				{raw_data.lane[k], prev_data.lane[k]} >> (hispi_pkg::slice_w - offset));
		end
	end

	// ----------------------------------------
	// registers
	// ----------------------------------------
	// data path only
	always_ff @(posedge clk) begin
		prev_data   <= raw_data;
		raw_shifted <= sel_data;
	end

	// ----------------------------------------
	// checks
	// ----------------------------------------
	// offset stays inside one slice across any bitslip sequence
	a_offset_range: assert property (
		@(posedge clk) disable iff (!rst_n)
		offset <= hispi_pkg::slip_max
	);

endmodule

// ==== project.f ====
hispi_pkg.sv
lane_gearbox.sv
word_aligner.sv
sync_decoder.sv
hispi_rx.sv
hispi_sensor_model.sv
hispi_rx_tb.sv

// ==== sync_decoder.sv ====
// hispi sync decoder
// turns sync plus code words into frame and line markers and a pixel strobe
`timescale 1ns/100ps

module sync_decoder (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    word_stb,
	input  hispi_pkg::word_bundle_t words,
	output logic                    frame_start,
	output logic                    line_start,
	output logic                    line_end,
	output logic                    frame_end,
	output logic                    pixel_valid,
	output hispi_pkg::word_bundle_t pixels
);

	hispi_pkg::dec_state_t state;
	hispi_pkg::word_t      lane0;
	// start of a new sync sequence
	logic                  sync_start;
	// pixel word in this clk
	logic                  pixel_hit;

	// only lane 0 carries the protocol
	assign lane0      = words.lane[0];
	assign sync_start = (lane0 == hispi_pkg::sync_word_0);
	assign pixel_hit  = word_stb && (state == hispi_pkg::active) && !sync_start;

	// ----------------------------------------
	// fsm and markers
	// ----------------------------------------
	// steps only on word_stb
	// all pulses last one clk
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= hispi_pkg::idle;
			frame_start <= 1'b0;
			line_start  <= 1'b0;
			line_end    <= 1'b0;
			frame_end   <= 1'b0;
			pixel_valid <= 1'b0;
		end else begin
			frame_start <= 1'b0;
			line_start  <= 1'b0;
			line_end    <= 1'b0;
			frame_end   <= 1'b0;
			pixel_valid <= pixel_hit;
			if (word_stb) begin
				case (state)
					hispi_pkg::idle: begin
						if (sync_start) begin
							state <= hispi_pkg::sync1;
						end
					end
					hispi_pkg::sync1: begin
						if (lane0 == hispi_pkg::sync_word_1) begin
							state <= hispi_pkg::sync2;
						end else begin
							state <= hispi_pkg::idle;
						end
					end
					hispi_pkg::sync2: begin
						if (lane0 == hispi_pkg::sync_word_2) begin
							state <= hispi_pkg::code;
						end else begin
							state <= hispi_pkg::idle;
						end
					end
					hispi_pkg::code: begin
						// start codes open a payload, end codes close the line
						case (lane0)
							hispi_pkg::code_sof: begin
								frame_start <= 1'b1;
								state       <= hispi_pkg::active;
							end
							hispi_pkg::code_sol: begin
								line_start <= 1'b1;
								state      <= hispi_pkg::active;
							end
							hispi_pkg::code_eof: begin
								frame_end <= 1'b1;
								state     <= hispi_pkg::idle;
							end
							hispi_pkg::code_eol: begin
								line_end <= 1'b1;
								state    <= hispi_pkg::idle;
							end
							default: begin
								state <= hispi_pkg::idle;
							end
						endcase
					end
					hispi_pkg::active: begin
						// next sync ends the payload
						if (sync_start) begin
							state <= hispi_pkg::sync1;
						end
					end
					default: begin
						state <= hispi_pkg::idle;
					end
				endcase
			end
		end
	end

	// ----------------------------------------
	// pixel data
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (pixel_hit) begin
			pixels <= words;
		end
	end

	// ----------------------------------------
	// checks
	// ----------------------------------------
	// markers are mutually exclusive
	a_one_marker: assert property (
		@(posedge clk) disable iff (!rst_n)
		$onehot0({frame_start, line_start, line_end, frame_end})
	);

endmodule

// ==== word_aligner.sv ====
// hispi word aligner
// finds the sync on lane 0, holds lock, times bitslips and builds 12-bit words
`timescale 1ns/100ps

module word_aligner (
	input  logic                    clk,
	input  logic                    rst_n,
	input  hispi_pkg::raw_bundle_t  raw_shifted,
	input  hispi_pkg::line_len_t    line_length,
	input  logic                    align_en,
	output logic                    bitslip,
	output logic                    locked,
	output logic                    word_stb,
	output hispi_pkg::word_bundle_t words
);

	// two flop synchroniser for the enable
	logic [1:0] en_sync;
	logic       enabled;

	// lane 0 history, newest slice at the top
	logic [hispi_pkg::hist_w-1:0] history;
	logic                         sync_hit;

	// line period counter
	hispi_pkg::line_len_t period_cnt;
	logic                 period_wrap;

	// ----------------------------------------
	// enable sync
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			en_sync <= 2'b00;
		end else begin
			en_sync <= {en_sync[0], align_en};
		end
	end

	assign enabled = en_sync[1];

	// ----------------------------------------
	// sync search on lane 0
	// ----------------------------------------
	// lsb first so new slices enter from the top
	always_ff @(posedge clk) begin
		history <= {raw_shifted.lane[0], history[hispi_pkg::hist_w-1:hispi_pkg::slice_w]};
	end

	assign sync_hit = (history == hispi_pkg::sync_seq);

	// sticky until the enable drops
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			locked <= 1'b0;
		end else if (!enabled) begin
			locked <= 1'b0;
		end else if (sync_hit) begin
			locked <= 1'b1;
		end
	end

	// ----------------------------------------
	// word strobe and assembly
	// ----------------------------------------
	// toggles every clk once locked
	// cleared together with the lock so it never outlives it
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			word_stb <= 1'b0;
		end else if (!enabled || !locked) begin
			word_stb <= 1'b0;
		end else begin
			word_stb <= ~word_stb;
		end
	end

	// earlier slice ends up in the low half
	always_ff @(posedge clk) begin
		for (int k = 0; k < hispi_pkg::lane_num; k++) begin
			words.lane[k] <= {raw_shifted.lane[k],
				words.lane[k][hispi_pkg::word_w-1:hispi_pkg::slice_w]};
		end
	end

	// ----------------------------------------
	// bitslip timing
	// ----------------------------------------
	assign period_wrap = (period_cnt == line_length);

	// runs 0 .. line_length while enabled
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			period_cnt <= '0;
		end else if (!enabled || period_wrap) begin
			period_cnt <= '0;
		end else begin
			period_cnt <= period_cnt + 1'b1;
		end
	end

	// one slip chance per line
	// skipped when a sync shows up on the same clk
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bitslip <= 1'b0;
		end else begin
			bitslip <= enabled && period_wrap && !locked && !sync_hit;
		end
	end

	// ----------------------------------------
	// checks
	// ----------------------------------------
	// a slip after lock would tear the word boundary
	a_no_slip_locked: assert property (
		@(posedge clk) disable iff (!rst_n)
		bitslip |-> !locked
	);

	// no words leave the aligner without lock
	a_stb_needs_lock: assert property (
		@(posedge clk) disable iff (!rst_n)
		!locked |-> !word_stb
	);

endmodule
